// ==== ncore_top.f ====
+incdir+source
source/ncore_pkg.sv
source/ncore_alu.sv
source/ncore_ram.sv
source/ncore_core.sv
source/ncore_csr.sv
source/ncore_top.sv
testbench/ncore_sva.sv
testbench/ncore_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ncore testbench with Verilator from the project root.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
	--top-module ncore_tb \
	-f ncore_top.f \
	-o Vncore_tb &&
./obj_dir/Vncore_tb | grep "Test passed" ||
{
	echo "Simulation did not pass"
	exit 1
}

// ==== source/ncore_alu.sv ====
`include "ncore_macros.svh"

module ncore_alu (
	input  ncore_pkg::word_t i_a,
	input  ncore_pkg::word_t i_b,
	output ncore_pkg::word_t o_add,
	output ncore_pkg::word_t o_sub,
	output ncore_pkg::word_t o_shl,
	output ncore_pkg::word_t o_shr,
	output ncore_pkg::word_t o_and,
	output ncore_pkg::word_t o_orr,
	output ncore_pkg::word_t o_xor,
	output logic             o_c_add,
	output logic             o_c_sub,
	output logic             o_c_shl,
	output logic             o_c_shr
);

	// One extra bit on every result to catch the carry
	logic [`NCORE_DW:0] add_x;
	logic [`NCORE_DW:0] sub_x;
	logic [`NCORE_DW:0] shl_x;
	logic [`NCORE_DW:0] shr_x;
	logic [3:0]         shamt;

	assign shamt = i_b[3:0]; // Shift distance 0..15

	// Arithmetic, unsigned
	assign add_x = {1'b0, i_a} + {1'b0, i_b};
	assign sub_x = {1'b0, i_a} - {1'b0, i_b}; // MSB is the borrow

	// Guard bit above the word collects the last bit out of the top
	assign shl_x = {1'b0, i_a} << shamt;
	// Guard bit below the word collects the last bit out of the bottom
	assign shr_x = {i_a, 1'b0} >> shamt;

	assign {o_c_add, o_add} = add_x;
	assign {o_c_sub, o_sub} = sub_x;
	assign {o_c_shl, o_shl} = shl_x;
	assign {o_shr, o_c_shr} = shr_x;

	// Logic ops, no carry
	assign o_and = i_a & i_b;
	assign o_orr = i_a | i_b;
	assign o_xor = i_a ^ i_b;

endmodule

// ==== source/ncore_core.sv ====
`include "ncore_macros.svh"

module ncore_core (
	input  logic                clk,
	input  logic                i_rst_n,
	input  logic                i_run,
	input  ncore_pkg::wdt_t     i_wdt_limit,
	input  ncore_pkg::instr_t   i_instr,
	input  ncore_pkg::word_t    i_drdata,
	input  ncore_pkg::regidx_t  i_dbg_sel,
	output ncore_pkg::word_t    o_iaddr,
	output ncore_pkg::word_t    o_daddr,
	output ncore_pkg::word_t    o_dwdata,
	output logic                o_dwe,
	output ncore_pkg::word_t    o_ip,
	output logic                o_int_mode,
	output ncore_pkg::flags_t   o_flags,
	output ncore_pkg::word_t    o_dbg_data
);
	import ncore_pkg::*;

	localparam int NREGS = 13; // General registers 0..12

	// Architectural state
	word_t   ip;
	word_t   dp;
	word_t   a;
	word_t   b;
	word_t   mask;  // Task mask, written via index 15 in interrupt mode
	word_t   regs [0:NREGS-1];
	flags_t  flags;
	wdt_t    wdt;
	logic    int_mode;

	// Decode and datapath
	opcode_t op;
	regidx_t idx;
	word_t   konst;
	word_t   src;   // Operand selected by idx
	word_t   c;     // Result of this instruction
	word_t   imask;
	word_t   dmask;
	flags_t  flags_new;
	word_t   r_add, r_sub, r_shl, r_shr, r_and, r_orr, r_xor;
	logic    c_add, c_sub, c_shl, c_shr;
	logic    alu_op;
	logic    wr_reg;
	logic    jmp_taken;
	logic    wdt_fire;
	logic    exc_save;

	// Register index map: 15 flags, 14 memory at DP, 13 DP
	function automatic word_t read_reg(input regidx_t r);
		word_t v;
		case (r)
			4'd15:   v = word_t'(flags);
			4'd14:   v = i_drdata;
			4'd13:   v = dp;
			default: v = regs[r];
		endcase
		return v;
	endfunction

	assign op    = opcode_t'(i_instr[7:4]);
	assign idx   = regidx_t'(i_instr[3:0]);
	assign konst = word_t'(idx); // Zero-extended constant

	always_comb src = read_reg(idx);

	ncore_alu u_alu (
		.i_a     (a),
		.i_b     (b),
		.o_add   (r_add),
		.o_sub   (r_sub),
		.o_shl   (r_shl),
		.o_shr   (r_shr),
		.o_and   (r_and),
		.o_orr   (r_orr),
		.o_xor   (r_xor),
		.o_c_add (c_add),
		.o_c_sub (c_sub),
		.o_c_shl (c_shl),
		.o_c_shr (c_shr)
	);

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////
	assign alu_op    = (op >= OP_SHL) && (op <= OP_SUB); // Contiguous ALU opcodes
	assign wr_reg    = alu_op || (op == OP_IMV);
	assign jmp_taken = (op == OP_JMP) && a[0];
	// Watchdog only preempts tasks, never the handler itself
	assign wdt_fire  = !int_mode && (wdt >= i_wdt_limit);
	assign exc_save  = !int_mode && (wdt_fire || (op == OP_INT));

	// Page masks, low bits are the in-page offset
	assign imask = word_t'(16'hFFFF >> mask[7:4]);
	assign dmask = word_t'(16'hFFFF >> mask[11:8]);

	always_comb
	begin
		case (op)
			OP_COA, OP_COB, OP_CSB: c = konst;
			OP_SHL:  c = r_shl;
			OP_SHR:  c = r_shr;
			OP_AND:  c = r_and;
			OP_ORR:  c = r_orr;
			OP_XOR:  c = r_xor;
			OP_ADD:  c = r_add;
			OP_SUB:  c = r_sub;
			OP_IMV:  c = ip;
			default: c = src; // mvA, mvB, jmp and the rest pass the operand
		endcase
	end

	//////////////////////////////////////////////////
	// Flags
	//////////////////////////////////////////////////
	always_comb
	begin
		flags_new = flags; // Sticky unless touched
		if (alu_op)
			flags_new[0] = (c == '0);
		if (op == OP_ADD)
			flags_new[1] = c_add;
		if (op == OP_SUB)
			flags_new[2] = c_sub;
		if (op == OP_SHL)
			flags_new[3] = c_shl;
		if (op == OP_SHR)
			flags_new[4] = c_shr;
		// Cause bits stay until the handler returns
		flags_new[5] = wdt_fire || (flags[5] && (op != OP_IRE));
		flags_new[9] = (op == OP_INT) || (flags[9] && (op != OP_IRE));
		// Protection checks apply to tasks only
		if (!int_mode)
		begin
			if (mask[1] && jmp_taken) // Jump leaves the code page
				flags_new[6] = (c & ~imask) != (ip & ~imask);
			if (mask[2] && wr_reg && (idx == 4'd13)) // DP leaves the data page
				flags_new[7] = (c & ~dmask) != (dp & ~dmask);
			// Save area 9..12 touched by a task
			if (mask[0] && (wr_reg || (op == OP_MVA) || (op == OP_MVB) || (op == OP_JMP)))
				flags_new[8] = (idx > 4'd8) && (idx < 4'd13);
		end
	end

	//////////////////////////////////////////////////
	// State update, one instruction per edge
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (!i_rst_n)
		begin
			ip       <= '0;
			dp       <= '0;
			a        <= '0;
			b        <= '0;
			mask     <= '0;
			flags    <= '0;
			wdt      <= '0;
			int_mode <= 1'b1; // Boot in handler mode to set up tasks
			for (int i = 0; i < NREGS; i++)
				regs[i] <= '0;
		end
		else if (i_run)
		begin
			flags <= flags_new;
			// Counts task cycles since the last int
			if ((op == OP_INT) || wdt_fire || int_mode)
				wdt <= '0;
			else
				wdt <= wdt + 1'b1;

			if (exc_save)
			begin
				// Watchdog abandons the instruction, int resumes after itself
				regs[12] <= wdt_fire ? ip : ip + 1'b1;
				regs[11] <= word_t'(flags_new);
				regs[10] <= a;
				regs[9]  <= b;
				ip       <= word_t'(`NCORE_INT_VECTOR);
				int_mode <= 1'b1;
			end
			else
			begin
				// Source registers
				case (op)
					OP_MVA, OP_COA: a <= c;
					OP_MVB, OP_COB: b <= c;
					OP_CSB:         b <= {8'h00, b[3:0], idx};
					default: ;
				endcase

				// Result writeback, index 14 goes out on o_dwe
				if (wr_reg)
				begin
					if (idx < 4'd13)
						regs[idx] <= c;
					else if (idx == 4'd13)
						dp <= int_mode ? c : ((dp & ~dmask) | (c & dmask)); // Stay in page
					else if ((idx == 4'd15) && int_mode)
						mask <= c;
				end

				// Instruction pointer
				if (jmp_taken)
					ip <= int_mode ? c : ((ip & ~imask) | (c & imask));
				else if (op == OP_INT)
					ip <= word_t'(`NCORE_INT_VECTOR); // Nested int, no save
				else if (op == OP_IRE)
				begin
					ip       <= regs[12];
					int_mode <= 1'b0;
				end
				else
					ip <= ip + 1'b1;
			end
		end
	end

	// Memory port at DP
	assign o_iaddr  = ip;
	assign o_daddr  = dp;
	assign o_dwdata = c;
	assign o_dwe    = i_run && wr_reg && (idx == 4'd14) && !wdt_fire;

	// Status back to the register block
	assign o_ip       = ip;
	assign o_int_mode = int_mode;
	assign o_flags    = flags;

	always_comb o_dbg_data = read_reg(i_dbg_sel);

endmodule

// ==== source/ncore_csr.sv ====
`include "ncore_macros.svh"

module ncore_csr (
	input  logic                      clk,
	input  logic                      i_rst_n,
	// AXI4-Lite slave
	input  logic [7:0]                i_awaddr,
	input  logic                      i_awvalid,
	output logic                      o_awready,
	input  logic [31:0]               i_wdata,
	input  logic                      i_wvalid,
	output logic                      o_wready,
	output logic [1:0]                o_bresp,
	output logic                      o_bvalid,
	input  logic                      i_bready,
	input  logic [7:0]                i_araddr,
	input  logic                      i_arvalid,
	output logic                      o_arready,
	output logic [31:0]               o_rdata,
	output logic [1:0]                o_rresp,
	output logic                      o_rvalid,
	input  logic                      i_rready,
	// Core control
	output logic                      o_run,
	output ncore_pkg::wdt_t           o_wdt_limit,
	output ncore_pkg::regidx_t        o_dbg_sel,
	// Memory host ports
	output logic [`NCORE_IMEM_AW-1:0] o_imem_addr,
	output ncore_pkg::instr_t         o_imem_wdata,
	output logic                      o_imem_we,
	output logic [`NCORE_DMEM_AW-1:0] o_dmem_addr,
	output ncore_pkg::word_t          o_dmem_wdata,
	output logic                      o_dmem_we,
	input  ncore_pkg::word_t          i_dmem_rdata,
	// Core status
	input  ncore_pkg::word_t          i_ip,
	input  logic                      i_int_mode,
	input  ncore_pkg::flags_t         i_flags,
	input  ncore_pkg::word_t          i_dbg_data
);
	import ncore_pkg::*;

	axi_wr_state_t wr_state;
	axi_rd_state_t rd_state;
	logic          wr_accept;
	logic          rd_accept;
	logic [31:0]   rd_mux;

	//////////////////////////////////////////////////
	// Write channel
	//////////////////////////////////////////////////
	assign o_awready = (wr_state == WR_IDLE);
	assign o_wready  = (wr_state == WR_IDLE);
	assign wr_accept = (wr_state == WR_IDLE) && i_awvalid && i_wvalid; // Address and data together
	assign o_bvalid  = (wr_state == WR_RESP);
	assign o_bresp   = 2'b00; // Always OKAY

	always_ff @(posedge clk)
	begin
		if (!i_rst_n)
		begin
			wr_state    <= WR_IDLE;
			o_run       <= 1'b0;
			o_wdt_limit <= '1;
			o_dbg_sel   <= '0;
			o_imem_addr <= '0;
			o_dmem_addr <= '0;
			o_imem_we   <= 1'b0;
			o_dmem_we   <= 1'b0;
		end
		else
		begin
			o_imem_we <= 1'b0; // Single-cycle pulses
			o_dmem_we <= 1'b0;
			if (o_imem_we)
				o_imem_addr <= o_imem_addr + 1'b1; // Streamed program load
			case (wr_state)
				WR_IDLE:
					if (wr_accept)
					begin
						wr_state <= WR_RESP;
						case (i_awaddr)
							`NCORE_CSR_CTRL:      o_run       <= i_wdata[0];
							`NCORE_CSR_WDT_LIMIT: o_wdt_limit <= i_wdata[`NCORE_WDT_W-1:0];
							`NCORE_CSR_DBG_SEL:   o_dbg_sel   <= i_wdata[3:0];
							`NCORE_CSR_IMEM_ADDR: o_imem_addr <= i_wdata[`NCORE_IMEM_AW-1:0];
							`NCORE_CSR_IMEM_DATA: o_imem_we   <= 1'b1;
							`NCORE_CSR_DMEM_ADDR: o_dmem_addr <= i_wdata[`NCORE_DMEM_AW-1:0];
							`NCORE_CSR_DMEM_DATA: o_dmem_we   <= 1'b1;
							default: ; // Read-only or unmapped
						endcase
					end
				WR_RESP:
					if (i_bready)
						wr_state <= WR_IDLE;
				default: wr_state <= WR_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Read channel
	//////////////////////////////////////////////////
	assign o_arready = (rd_state == RD_IDLE);
	assign rd_accept = (rd_state == RD_IDLE) && i_arvalid;
	assign o_rvalid  = (rd_state == RD_DATA);
	assign o_rresp   = 2'b00;

	always_comb
	begin
		case (i_araddr)
			`NCORE_CSR_CTRL:      rd_mux = 32'(o_run);
			`NCORE_CSR_WDT_LIMIT: rd_mux = 32'(o_wdt_limit);
			`NCORE_CSR_STATUS:    rd_mux = {15'h0000, i_int_mode, i_ip};
			`NCORE_CSR_FLAGS:     rd_mux = 32'(i_flags);
			`NCORE_CSR_DBG_SEL:   rd_mux = 32'(o_dbg_sel);
			`NCORE_CSR_DBG_DATA:  rd_mux = 32'(i_dbg_data);
			`NCORE_CSR_IMEM_ADDR: rd_mux = 32'(o_imem_addr);
			`NCORE_CSR_DMEM_ADDR: rd_mux = 32'(o_dmem_addr);
			`NCORE_CSR_DMEM_DATA: rd_mux = 32'(i_dmem_rdata); // Word at DMEM_ADDR
			default:              rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!i_rst_n)
			rd_state <= RD_IDLE;
		else
		begin
			case (rd_state)
				RD_IDLE:
					if (rd_accept)
						rd_state <= RD_DATA;
				RD_DATA:
					if (i_rready)
						rd_state <= RD_IDLE; // Hold data until taken
				default: rd_state <= RD_IDLE;
			endcase
		end
	end

	// Payload captures
	always_ff @(posedge clk)
	begin
		if (wr_accept)
		begin
			o_imem_wdata <= i_wdata[`NCORE_IW-1:0];
			o_dmem_wdata <= i_wdata[`NCORE_DW-1:0];
		end
		if (rd_accept)
			o_rdata <= rd_mux; // Snapshot at acceptance
	end

endmodule

// ==== source/ncore_macros.svh ====
`ifndef NCORE_MACROS_SVH
`define NCORE_MACROS_SVH

// Datapath widths
`define NCORE_DW         16
`define NCORE_IW         8
`define NCORE_IMEM_AW    8 // 256 program bytes
`define NCORE_DMEM_AW    8 // 256 data words
`define NCORE_INT_VECTOR 16 // Entry of the interrupt handler
`define NCORE_WDT_W      20

//////////////////////////////////////////////////
// AXI4-Lite register offsets
//////////////////////////////////////////////////
`define NCORE_CSR_CTRL      8'h00 // bit0 run
`define NCORE_CSR_WDT_LIMIT 8'h04
`define NCORE_CSR_STATUS    8'h08 // IP and interrupt mode
`define NCORE_CSR_FLAGS     8'h0C
`define NCORE_CSR_DBG_SEL   8'h10
`define NCORE_CSR_DBG_DATA  8'h14
`define NCORE_CSR_IMEM_ADDR 8'h18
`define NCORE_CSR_IMEM_DATA 8'h1C // Address steps after each write
`define NCORE_CSR_DMEM_ADDR 8'h20
`define NCORE_CSR_DMEM_DATA 8'h24

`endif

// ==== source/ncore_pkg.sv ====
`include "ncore_macros.svh"

package ncore_pkg;

	typedef logic [`NCORE_DW-1:0]    word_t;
	typedef logic [`NCORE_IW-1:0]    instr_t;
	typedef logic [3:0]              opcode_t; // Upper nibble of instr_t
	typedef logic [3:0]              regidx_t; // Lower nibble, register or constant
	typedef logic [9:0]              flags_t;
	typedef logic [`NCORE_WDT_W-1:0] wdt_t;

	// Opcodes in instruction set order
	localparam opcode_t OP_MVA = 4'd0;  // a <- reg
	localparam opcode_t OP_COA = 4'd1;  // a <- constant
	localparam opcode_t OP_MVB = 4'd2;  // b <- reg
	localparam opcode_t OP_COB = 4'd3;  // b <- constant
	localparam opcode_t OP_CSB = 4'd4;  // b[7:4] <- b[3:0], b[3:0] <- constant
	localparam opcode_t OP_SHL = 4'd5;
	localparam opcode_t OP_SHR = 4'd6;
	localparam opcode_t OP_AND = 4'd7;
	localparam opcode_t OP_ORR = 4'd8;
	localparam opcode_t OP_XOR = 4'd9;
	localparam opcode_t OP_ADD = 4'd10;
	localparam opcode_t OP_SUB = 4'd11;
	localparam opcode_t OP_INT = 4'd12; // Software interrupt
	localparam opcode_t OP_IRE = 4'd13; // Return to task
	localparam opcode_t OP_IMV = 4'd14; // reg <- IP
	localparam opcode_t OP_JMP = 4'd15; // IP <- reg when a[0]

	// AXI channel state machines
	typedef enum logic {WR_IDLE, WR_RESP} axi_wr_state_t;
	typedef enum logic {RD_IDLE, RD_DATA} axi_rd_state_t;

endpackage

// ==== source/ncore_ram.sv ====
module ncore_ram #(
	parameter int WIDTH      = 8,
	parameter int DEPTH_LOG2 = 8
) (
	input  logic                  clk,
	// Port A, core side
	input  logic [DEPTH_LOG2-1:0] i_a_addr,
	input  logic [WIDTH-1:0]      i_a_wdata,
	input  logic                  i_a_we,
	output logic [WIDTH-1:0]      o_a_rdata,
	// Port B, host side
	input  logic [DEPTH_LOG2-1:0] i_b_addr,
	input  logic [WIDTH-1:0]      i_b_wdata,
	input  logic                  i_b_we,
	output logic [WIDTH-1:0]      o_b_rdata
);

	logic [WIDTH-1:0] mem [0:(1 << DEPTH_LOG2)-1];

	// Asynchronous reads on both ports
	assign o_a_rdata = mem[i_a_addr];
	assign o_b_rdata = mem[i_b_addr];

	// Port A is written last, so it wins on an address collision
	always_ff @(posedge clk)
	begin
		if (i_b_we)
			mem[i_b_addr] <= i_b_wdata;
		if (i_a_we)
			mem[i_a_addr] <= i_a_wdata;
	end

endmodule

// ==== source/ncore_top.sv ====
`include "ncore_macros.svh"

module ncore_top (
	input  logic        clk,
	input  logic        i_rst_n,
	input  logic [7:0]  i_awaddr,
	input  logic        i_awvalid,
	output logic        o_awready,
	input  logic [31:0] i_wdata,
	input  logic        i_wvalid,
	output logic        o_wready,
	output logic [1:0]  o_bresp,
	output logic        o_bvalid,
	input  logic        i_bready,
	input  logic [7:0]  i_araddr,
	input  logic        i_arvalid,
	output logic        o_arready,
	output logic [31:0] o_rdata,
	output logic [1:0]  o_rresp,
	output logic        o_rvalid,
	input  logic        i_rready
);
	import ncore_pkg::*;

	// Register block to core
	logic                      run;
	wdt_t                      wdt_limit;
	regidx_t                   dbg_sel;
	// Host memory ports
	logic [`NCORE_IMEM_AW-1:0] imem_haddr;
	instr_t                    imem_hwdata;
	logic                      imem_hwe;
	logic [`NCORE_DMEM_AW-1:0] dmem_haddr;
	word_t                     dmem_hwdata;
	word_t                     dmem_hrdata;
	logic                      dmem_hwe;
	// Core memory ports and status
	word_t                     core_iaddr;
	instr_t                    core_instr;
	word_t                     core_daddr;
	word_t                     core_dwdata;
	word_t                     core_drdata;
	logic                      core_dwe;
	word_t                     core_ip;
	logic                      core_int_mode;
	flags_t                    core_flags;
	word_t                     core_dbg;

	ncore_csr u_csr (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.i_awaddr     (i_awaddr),
		.i_awvalid    (i_awvalid),
		.o_awready    (o_awready),
		.i_wdata      (i_wdata),
		.i_wvalid     (i_wvalid),
		.o_wready     (o_wready),
		.o_bresp      (o_bresp),
		.o_bvalid     (o_bvalid),
		.i_bready     (i_bready),
		.i_araddr     (i_araddr),
		.i_arvalid    (i_arvalid),
		.o_arready    (o_arready),
		.o_rdata      (o_rdata),
		.o_rresp      (o_rresp),
		.o_rvalid     (o_rvalid),
		.i_rready     (i_rready),
		.o_run        (run),
		.o_wdt_limit  (wdt_limit),
		.o_dbg_sel    (dbg_sel),
		.o_imem_addr  (imem_haddr),
		.o_imem_wdata (imem_hwdata),
		.o_imem_we    (imem_hwe),
		.o_dmem_addr  (dmem_haddr),
		.o_dmem_wdata (dmem_hwdata),
		.o_dmem_we    (dmem_hwe),
		.i_dmem_rdata (dmem_hrdata),
		.i_ip         (core_ip),
		.i_int_mode   (core_int_mode),
		.i_flags      (core_flags),
		.i_dbg_data   (core_dbg)
	);

	ncore_core u_core (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_run       (run),
		.i_wdt_limit (wdt_limit),
		.i_instr     (core_instr),
		.i_drdata    (core_drdata),
		.i_dbg_sel   (dbg_sel),
		.o_iaddr     (core_iaddr),
		.o_daddr     (core_daddr),
		.o_dwdata    (core_dwdata),
		.o_dwe       (core_dwe),
		.o_ip        (core_ip),
		.o_int_mode  (core_int_mode),
		.o_flags     (core_flags),
		.o_dbg_data  (core_dbg)
	);

	// Program memory, core reads on A, host loads on B
	ncore_ram #(
		.WIDTH      (`NCORE_IW),
		.DEPTH_LOG2 (`NCORE_IMEM_AW)
	) u_imem (
		.clk       (clk),
		.i_a_addr  (core_iaddr[`NCORE_IMEM_AW-1:0]), // Upper IP bits wrap
		.i_a_wdata ('0),
		.i_a_we    (1'b0),
		.o_a_rdata (core_instr),
		.i_b_addr  (imem_haddr),
		.i_b_wdata (imem_hwdata),
		.i_b_we    (imem_hwe),
		.o_b_rdata ()
	);

	// Data memory, core on A has priority
	ncore_ram #(
		.WIDTH      (`NCORE_DW),
		.DEPTH_LOG2 (`NCORE_DMEM_AW)
	) u_dmem (
		.clk       (clk),
		.i_a_addr  (core_daddr[`NCORE_DMEM_AW-1:0]),
		.i_a_wdata (core_dwdata),
		.i_a_we    (core_dwe),
		.o_a_rdata (core_drdata),
		.i_b_addr  (dmem_haddr),
		.i_b_wdata (dmem_hwdata),
		.i_b_we    (dmem_hwe),
		.o_b_rdata (dmem_hrdata)
	);

endmodule

// ==== testbench/ncore_sva.sv ====
module ncore_sva (
	input logic clk,
	input logic i_rst_n,
	input logic o_bvalid,
	input logic i_bready,
	input logic o_rvalid,
	input logic i_rready,
	input logic o_run
);

	//////////////////////////////////////////////////
	// AXI response channels
	//////////////////////////////////////////////////

	// Write response stays up until the host takes it
	property bvalid_held;
		@(posedge clk) disable iff (!i_rst_n)
			(o_bvalid && !i_bready) |=> o_bvalid;
	endproperty

	property rvalid_held;
		@(posedge clk) disable iff (!i_rst_n)
			(o_rvalid && !i_rready) |=> o_rvalid;
	endproperty

	// Synchronous reset clears both responses and stops the core
	property idle_after_reset;
		@(posedge clk) !i_rst_n |=> (!o_bvalid && !o_rvalid && !o_run);
	endproperty

	assert property (bvalid_held)
		else $error("bvalid dropped before bready");
	assert property (rvalid_held)
		else $error("rvalid dropped before rready");
	assert property (idle_after_reset)
		else $error("CSR outputs not idle after reset");

endmodule

bind ncore_csr ncore_sva u_sva (
	.clk      (clk),
	.i_rst_n  (i_rst_n),
	.o_bvalid (o_bvalid),
	.i_bready (i_bready),
	.o_rvalid (o_rvalid),
	.i_rready (i_rready),
	.o_run    (o_run)
);

// ==== testbench/ncore_tb.sv ====
`include "ncore_macros.svh"

module ncore_tb;

	localparam int HANDSHAKE_LIMIT = 100; // Cycles per AXI wait
	localparam int POLL_LIMIT      = 400; // STATUS reads per run

	logic        clk;
	logic        i_rst_n;
	logic [7:0]  i_awaddr;
	logic        i_awvalid;
	logic        o_awready;
	logic [31:0] i_wdata;
	logic        i_wvalid;
	logic        o_wready;
	logic [1:0]  o_bresp;
	logic        o_bvalid;
	logic        i_bready;
	logic [7:0]  i_araddr;
	logic        i_arvalid;
	logic        o_arready;
	logic [31:0] o_rdata;
	logic [1:0]  o_rresp;
	logic        o_rvalid;
	logic        i_rready;

	ncore_top uut (
		.clk       (clk),
		.i_rst_n   (i_rst_n),
		.i_awaddr  (i_awaddr),
		.i_awvalid (i_awvalid),
		.o_awready (o_awready),
		.i_wdata   (i_wdata),
		.i_wvalid  (i_wvalid),
		.o_wready  (o_wready),
		.o_bresp   (o_bresp),
		.o_bvalid  (o_bvalid),
		.i_bready  (i_bready),
		.i_araddr  (i_araddr),
		.i_arvalid (i_arvalid),
		.o_arready (o_arready),
		.o_rdata   (o_rdata),
		.o_rresp   (o_rresp),
		.o_rvalid  (o_rvalid),
		.i_rready  (i_rready)
	);

	always #4 clk = ~clk; // Period 8

	//////////////////////////////////////////////////
	// Failure reporting
	//////////////////////////////////////////////////
	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at time %0t while waiting for %s", $time, what);
		abort_run();
	endtask

	task automatic expect_equal(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("MISMATCH at time %0t: %s read %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	//////////////////////////////////////////////////
	// AXI4-Lite host
	//////////////////////////////////////////////////
	task automatic drive_idle();
		i_awaddr  = '0;
		i_awvalid = 1'b0;
		i_wdata   = '0;
		i_wvalid  = 1'b0;
		i_bready  = 1'b0;
		i_araddr  = '0;
		i_arvalid = 1'b0;
		i_rready  = 1'b0;
	endtask

	task automatic apply_reset();
		drive_idle();
		i_rst_n = 1'b0;
		repeat (8) @(negedge clk);
		i_rst_n = 1'b1;
	endtask

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
		int n;
		@(negedge clk);
		i_awaddr  = addr;
		i_wdata   = data;
		i_awvalid = 1'b1;
		i_wvalid  = 1'b1;
		n = 0;
		while (!o_awready)
		begin
			if (n >= HANDSHAKE_LIMIT)
				report_timeout("awready");
			else
			begin
				@(negedge clk);
				n++;
			end
		end
		@(negedge clk); // Accepted on the edge just passed
		i_awvalid = 1'b0;
		i_wvalid  = 1'b0;
		repeat ($urandom % 4) @(negedge clk); // Random back-pressure
		i_bready = 1'b1;
		n = 0;
		while (!o_bvalid)
		begin
			if (n >= HANDSHAKE_LIMIT)
				report_timeout("bvalid");
			else
			begin
				@(negedge clk);
				n++;
			end
		end
		expect_equal("write response", 32'(o_bresp), 32'h0); // OKAY
		@(negedge clk);
		i_bready = 1'b0;
	endtask

	task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
		int n;
		@(negedge clk);
		i_araddr  = addr;
		i_arvalid = 1'b1;
		n = 0;
		while (!o_arready)
		begin
			if (n >= HANDSHAKE_LIMIT)
				report_timeout("arready");
			else
			begin
				@(negedge clk);
				n++;
			end
		end
		@(negedge clk);
		i_arvalid = 1'b0;
		repeat ($urandom % 4) @(negedge clk);
		i_rready = 1'b1;
		n = 0;
		while (!o_rvalid)
		begin
			if (n >= HANDSHAKE_LIMIT)
				report_timeout("rvalid");
			else
			begin
				@(negedge clk);
				n++;
			end
		end
		data = o_rdata; // Stable while rvalid waits for the handshake
		expect_equal("read response", 32'(o_rresp), 32'h0); // OKAY
		@(negedge clk);
		i_rready = 1'b0;
	endtask

	task automatic read_and_check(input string what, input logic [7:0] addr,
		input logic [31:0] exp);
		logic [31:0] got;
		axi_read(addr, got);
		expect_equal(what, got, exp);
	endtask

	//////////////////////////////////////////////////
	// Program execution
	//////////////////////////////////////////////////

	// Run until IP sits on the closing self-jump, then freeze the core
	task automatic run_to_loop(input logic [15:0] target);
		logic [31:0] status;
		int          n;
		axi_write(`NCORE_CSR_CTRL, 32'd1);
		axi_read(`NCORE_CSR_STATUS, status);
		n = 0;
		while (status[15:0] != target)
		begin
			if (n >= POLL_LIMIT)
				report_timeout("IP to reach the end loop");
			else
			begin
				axi_read(`NCORE_CSR_STATUS, status);
				n++;
			end
		end
		axi_write(`NCORE_CSR_CTRL, 32'd0);
		axi_read(`NCORE_CSR_STATUS, status);
		expect_equal("final IP", 32'(status[15:0]), 32'(target));
	endtask

	// Reset state and host register access
	task automatic check_reset_state();
		logic [31:0] sel;
		read_and_check("WDT_LIMIT after reset", `NCORE_CSR_WDT_LIMIT, 32'h000F_FFFF);
		read_and_check("CTRL after reset", `NCORE_CSR_CTRL, 32'h0);
		read_and_check("STATUS after reset", `NCORE_CSR_STATUS, 32'h0001_0000);
		for (int i = 0; i < 6; i++)
		begin
			sel = $urandom % 16;
			axi_write(`NCORE_CSR_DBG_SEL, sel);
			read_and_check("DBG_SEL readback", `NCORE_CSR_DBG_SEL, sel);
		end
	endtask

	// Record letters T, P and H set up a test, G runs it, R, M and F check it
	task automatic run_test_file();
		int            fd;
		int            code;
		int            count;
		logic [63:0]   tok;
		logic [1023:0] line;
		logic [31:0]   wdt_lim;
		logic [31:0]   final_ip;
		logic [31:0]   key;
		logic [31:0]   val;
		fd = $fopen("testbench/ncore_testdata.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the test data file");
			abort_run();
		end
		while (!$feof(fd))
		begin
			code = $fscanf(fd, "%s", tok);
			if (code == 1)
			begin
				case (tok)
					"#": code = $fgets(line, fd); // Comment line
					"T":
					begin
						code = $fscanf(fd, "%h %h", wdt_lim, final_ip);
						apply_reset();
						axi_write(`NCORE_CSR_WDT_LIMIT, wdt_lim);
					end
					"P":
					begin
						code = $fscanf(fd, "%d", count);
						axi_write(`NCORE_CSR_IMEM_ADDR, 32'h0);
						for (int i = 0; i < count; i++)
						begin
							code = $fscanf(fd, "%h", val);
							axi_write(`NCORE_CSR_IMEM_DATA, val); // Address steps itself
						end
					end
					"H":
					begin
						code = $fscanf(fd, "%h %h", key, val);
						axi_write(`NCORE_CSR_DMEM_ADDR, key);
						axi_write(`NCORE_CSR_DMEM_DATA, val);
					end
					"G": run_to_loop(final_ip[15:0]);
					"R":
					begin
						code = $fscanf(fd, "%h %h", key, val);
						axi_write(`NCORE_CSR_DBG_SEL, key);
						read_and_check("core register", `NCORE_CSR_DBG_DATA, val);
					end
					"M":
					begin
						code = $fscanf(fd, "%h %h", key, val);
						axi_write(`NCORE_CSR_DMEM_ADDR, key);
						read_and_check("data memory word", `NCORE_CSR_DMEM_DATA, val);
					end
					"F":
					begin
						code = $fscanf(fd, "%h", val);
						read_and_check("FLAGS", `NCORE_CSR_FLAGS, val);
					end
					default:
					begin
						$display("Unknown record in the test data file");
						abort_run();
					end
				endcase
			end
		end
		$fclose(fd);
	endtask

	initial
	begin
		clk = 1'b0;
		i_rst_n = 1'b0;
		drive_idle();
		void'($urandom(36));
		apply_reset();
		check_reset_state();
		run_test_file();
		$display("Test passed");
		$finish;
	end

endmodule

// ==== testbench/ncore_testdata.txt ====
# Records: T wdt_limit final_ip | P count bytes | H dmem_addr word | G run
# Checks:  R reg_index value | M dmem_addr word | F flags
# ALU and flags
T FFFFF 19
P 26 15 33 A0 B1 12 B2 49 73 84 95 1F 32 56 67 02 A8 59 30 0F 8A
 10 31 49 8B 11 FB
G
R 0 0008
R 1 0002
R 2 FFFF
R 3 0000
R 4 003B
R 5 003B
R 6 003C
R 7 0003
R 8 0001
R 9 FFFC
R A 001E
R B 0019
F 01E
# Data memory through DP and index 14
T FFFFF 10
P 17 10 35 8D 17 AE 10 36 8D 0E 30 80 10 31 40 81 11 F1
H 06 BEEF
G
R 0 BEEF
R 1 0010
R D 0006
R E BEEF
M 05 000C
M 06 BEEF
F 000
# Return to task, then software interrupt
T FFFFF 15
P 35 10 32 40 8C D0 00 00 00 00 00 00 00 00 00 00 00
 10 31 45 80 11 F0 00 00 00 00 00 00 00 00 00 00 1A 37 C0
G
R 0 0015
R 9 0007
R A 000A
R B 0200
R C 0023
F 200
# Watchdog preempts a looping task
T 00005 15
P 38 10 32 40 8C D0 00 00 00 00 00 00 00 00 00 00 00
 10 31 45 80 11 F0 00 00 00 00 00 00 00 00 00 00 10 32 45 81 11 F1
G
R 1 0025
R 9 0025
R A 0001
R B 0020
R C 0025
F 020
# Restricted register and page masking
T FFFFF 29
P 42 10 3C 43 8F 10 32 40 8C D0 00 00 00 00 00 00 00
 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
 0A 30 0F 82 10 34 49 83 11 F3
G
R 2 0100
R 3 0049
R C 0020
F 040
